// File: zports_macros.svh
////////////////////
// port addresses, extension register indices and reset values
// for the z80 i/o port block
////////////////////
`ifndef ZPORTS_MACROS_SVH
`define ZPORTS_MACROS_SVH

// low address byte of the kept ports
`define PORT_FE       8'hFE
`define PORT_F6       8'hF6
`define PORT_FD       8'hFD   // 7ffd paging
`define PORT_F7       8'hF7   // eff7
`define PORT_XT       8'hAF   // extension port #nnAF
`define PORT_BF       8'hBF   // shadow enable, nmi set
`define PORT_BE       8'hBE   // nmi end
`define PORT_KJOY     8'h1F
`define PORT_KMOUSE   8'hDF

////////////////////
// extension register index, high address byte of #nnAF
`define XT_STAT       8'h00   // read side of index 00
`define XT_VCONF      8'h00
`define XT_VPAGE      8'h01
`define XT_X_OFFSL    8'h02
`define XT_X_OFFSH    8'h03
`define XT_Y_OFFSL    8'h04
`define XT_Y_OFFSH    8'h05
`define XT_TSCONF     8'h06
`define XT_PALSEL     8'h07
`define XT_BORDER     8'h0F
`define XT_RAMPAGE    8'h10   // 10..13
`define XT_FMADDR     8'h15
`define XT_TGPAGE     8'h18
`define XT_SYSCONF    8'h20
`define XT_MEMCONF    8'h21
`define XT_HINT       8'h22
`define XT_VINT_L     8'h23
`define XT_VINT_H     8'h24
`define XT_IM2VECT    8'h25
`define XT_FDDVIRT    8'h29
`define XT_OVERR      8'h2A

// dma setup registers
`define XT_DMA_SADDRL 8'h1A
`define XT_DMA_SADDRH 8'h1B
`define XT_DMA_SADDRX 8'h1C
`define XT_DMA_DADDRL 8'h1D
`define XT_DMA_DADDRH 8'h1E
`define XT_DMA_DADDRX 8'h1F
`define XT_DMA_LEN    8'h26
`define XT_DMA_CTRL   8'h27
`define XT_DMA_NUM    8'h28

////////////////////
// reset values, atm flavour
`define RST_SYSCONF   8'h01   // turbo 7 MHz
`define RST_RAMPAGE0  8'h00
`define RST_RAMPAGE1  8'h05
`define RST_RAMPAGE2  8'h02
`define RST_RAMPAGE3  8'h00
`define RST_IM2VECT   8'hFF

`endif

// File: z80bus_pkg.sv
////////////////////
// z80 bus view and i/o strobe types
////////////////////
package z80bus_pkg;

	// bus as seen by the port block
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  din;    // data written by the cpu
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} z80_bus_t;

	// one-cycle strobes, one per i/o cycle
	typedef struct packed
	{
		logic port_wr;
		logic port_rd;
	} io_pulse_t;

endpackage

// File: portcfg_pkg.sv
////////////////////
// port selects, configuration registers,
// video write strobes and paging state
////////////////////
package portcfg_pkg;

	// decoded port selects, one bit per port
	typedef struct packed
	{
		logic fe;
		logic f6;
		logic fd;
		logic f7;     // a8 qualified by shadow
		logic xt;
		logic bf;
		logic be;
		logic kjoy;   // outside shadow only
		logic kmouse;
	} port_sel_t;

	// extension port register file
	typedef struct packed
	{
		logic [7:0] sysconf;
		logic [7:0] memconf;
		logic [7:0] im2vect;
		logic [3:0] fddvirt;
		logic [4:0] fmaddr;
		logic [3:0] xt_override;   // per-window page override
	} xt_cfg_t;

	// video write strobes
	typedef struct packed
	{
		logic zborder;
		logic border;
		logic zvpage;
		logic vpage;
		logic vconf;
		logic x_offsl;
		logic x_offsh;
		logic y_offsl;
		logic y_offsh;
		logic tsconf;
		logic palsel;
		logic tgpage;
		logic hint_beg;
		logic vint_begl;
		logic vint_begh;
	} vid_wr_t;

	typedef struct packed
	{
		logic [7:0] p7ffd;
		logic [7:0] peff7_raw;   // before the block1m mask
	} paging_t;

endpackage

// File: io_strobe.sv
////////////////////
// i/o cycle edge detector
////////////////////
`timescale 1ns/1ps

module io_strobe
	import z80bus_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,
	input  z80_bus_t  bus,
	output io_pulse_t pulse
);

	logic iowr;
	logic iord;
	logic iowr_q;   // level seen last cycle
	logic iord_q;

	assign iowr = ~(bus.iorq_n | bus.wr_n);
	assign iord = ~(bus.iorq_n | bus.rd_n);

	// leading edge only, a held cycle gives one pulse
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q        <= 1'b0;
			iord_q        <= 1'b0;
			pulse.port_wr <= 1'b0;
			pulse.port_rd <= 1'b0;
		end
		else
		begin
			iowr_q        <= iowr;
			iord_q        <= iord;
			pulse.port_wr <= iowr & ~iowr_q;
			pulse.port_rd <= iord & ~iord_q;
		end
	end

endmodule

// File: port_decode.sv
////////////////////
// low address byte decoder, porthit and dataout
////////////////////
`timescale 1ns/1ps
`include "zports_macros.svh"

module port_decode
	import z80bus_pkg::*;
	import portcfg_pkg::*;
(
	input  z80_bus_t  bus,
	input  logic      shadow,
	output port_sel_t sel,
	output logic      porthit,
	output logic      dataout
);

	logic [7:0] loa;
	logic       f7_addr;
	logic       iord;

	assign loa     = bus.addr[7:0];
	assign f7_addr = (loa == `PORT_F7);
	assign iord    = ~(bus.iorq_n | bus.rd_n);

	////////////////////
	// selects
	assign sel.fe     = (loa == `PORT_FE);
	assign sel.f6     = (loa == `PORT_F6);
	assign sel.fd     = (loa == `PORT_FD);
	assign sel.xt     = (loa == `PORT_XT);
	assign sel.bf     = (loa == `PORT_BF);
	assign sel.be     = (loa == `PORT_BE);
	assign sel.kmouse = (loa == `PORT_KMOUSE);

	// joystick shares 1F with the fdc command port in shadow mode
	assign sel.kjoy = (loa == `PORT_KJOY) & ~shadow;

	// xEF7 style: a8 set in normal mode, cleared in shadow mode
	assign sel.f7 = f7_addr & (bus.addr[8] ^ shadow);

	////////////////////
	// internal port hit, keeps the external bus off
	assign porthit = sel.fe | sel.f6 | sel.fd | sel.xt
		| sel.bf | sel.be | sel.kmouse | sel.kjoy
		| (f7_addr & ~shadow);   // f7 counted outside shadow only

	assign dataout = porthit & iord;

endmodule

// File: xt_regs.sv
////////////////////
// extension port #nnAF register file
// video and dma write strobes
////////////////////
`timescale 1ns/1ps
`include "zports_macros.svh"

module xt_regs
	import z80bus_pkg::*;
	import portcfg_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  z80_bus_t    bus,
	input  logic        sel_xt,
	input  io_pulse_t   pulse,
	input  logic        p7ffd_wr,
	output xt_cfg_t     cfg,
	output logic [31:0] xt_page,
	output vid_wr_t     vid_wr,
	input  logic        sel_fe,
	output logic [8:0]  dmaport_wr,
	output logic        p7ffd_rom,
	output logic        romrw_en
);

	logic [7:0]      hoa;       // register index
	logic            xt_wr;
	logic            rp_hit;    // one of the four page windows
	logic            lock128;
	logic [3:0][7:0] rampage;

	assign hoa     = bus.addr[15:8];
	assign xt_wr   = sel_xt & pulse.port_wr;
	assign rp_hit  = ((hoa & 8'hFC) == `XT_RAMPAGE);
	assign lock128 = (cfg.memconf[7:6] == 2'b01);

	assign xt_page   = rampage;
	assign p7ffd_rom = cfg.memconf[0];
	assign romrw_en  = cfg.memconf[1];

	////////////////////
	// registers
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			cfg.sysconf     <= `RST_SYSCONF;
			cfg.memconf     <= 8'h00;   // atm mode
			cfg.im2vect     <= `RST_IM2VECT;
			cfg.fddvirt     <= 4'h0;
			cfg.fmaddr      <= 5'h00;
			cfg.xt_override <= 4'h0;
			rampage[0]      <= `RST_RAMPAGE0;
			rampage[1]      <= `RST_RAMPAGE1;
			rampage[2]      <= `RST_RAMPAGE2;
			rampage[3]      <= `RST_RAMPAGE3;
		end
		else if (p7ffd_wr)
		begin
			// 128k paging through 7ffd, upper bits dropped under lock128
			cfg.memconf[0] <= bus.din[4];
			rampage[3]     <= {3'b000, lock128 ? 2'b00 : bus.din[7:6], bus.din[2:0]};
		end
		else if (xt_wr)
		begin
			if (rp_hit)
			begin
				rampage[hoa[1:0]]         <= bus.din;
				cfg.xt_override[hoa[1:0]] <= 1'b1;   // page write turns override on
			end
			case (hoa)
				`XT_OVERR:   cfg.xt_override <= bus.din[3:0];
				`XT_FMADDR:  cfg.fmaddr      <= bus.din[4:0];
				`XT_SYSCONF: cfg.sysconf     <= bus.din;
				`XT_MEMCONF: cfg.memconf     <= bus.din;
				`XT_IM2VECT: cfg.im2vect     <= bus.din;
				`XT_FDDVIRT: cfg.fddvirt     <= bus.din[3:0];
				default:     ;
			endcase
		end
	end

	////////////////////
	// strobes, aligned with port_wr
	assign vid_wr.zborder   = sel_fe & pulse.port_wr;
	assign vid_wr.border    = xt_wr & (hoa == `XT_BORDER);
	assign vid_wr.zvpage    = p7ffd_wr;
	assign vid_wr.vpage     = xt_wr & (hoa == `XT_VPAGE);
	assign vid_wr.vconf     = xt_wr & (hoa == `XT_VCONF);
	assign vid_wr.x_offsl   = xt_wr & (hoa == `XT_X_OFFSL);
	assign vid_wr.x_offsh   = xt_wr & (hoa == `XT_X_OFFSH);
	assign vid_wr.y_offsl   = xt_wr & (hoa == `XT_Y_OFFSL);
	assign vid_wr.y_offsh   = xt_wr & (hoa == `XT_Y_OFFSH);
	assign vid_wr.tsconf    = xt_wr & (hoa == `XT_TSCONF);
	assign vid_wr.palsel    = xt_wr & (hoa == `XT_PALSEL);
	assign vid_wr.tgpage    = xt_wr & (hoa == `XT_TGPAGE);
	assign vid_wr.hint_beg  = xt_wr & (hoa == `XT_HINT);
	assign vid_wr.vint_begl = xt_wr & (hoa == `XT_VINT_L);
	assign vid_wr.vint_begh = xt_wr & (hoa == `XT_VINT_H);

	assign dmaport_wr[0] = xt_wr & (hoa == `XT_DMA_SADDRL);
	assign dmaport_wr[1] = xt_wr & (hoa == `XT_DMA_SADDRH);
	assign dmaport_wr[2] = xt_wr & (hoa == `XT_DMA_SADDRX);
	assign dmaport_wr[3] = xt_wr & (hoa == `XT_DMA_DADDRL);
	assign dmaport_wr[4] = xt_wr & (hoa == `XT_DMA_DADDRH);
	assign dmaport_wr[5] = xt_wr & (hoa == `XT_DMA_DADDRX);
	assign dmaport_wr[6] = xt_wr & (hoa == `XT_DMA_LEN);
	assign dmaport_wr[7] = xt_wr & (hoa == `XT_DMA_CTRL);
	assign dmaport_wr[8] = xt_wr & (hoa == `XT_DMA_NUM);

endmodule

// File: paging_regs.sv
////////////////////
// 7ffd, eff7 and bf registers, shadow flag, nmi controls
////////////////////
`timescale 1ns/1ps

module paging_regs
	import z80bus_pkg::*;
	import portcfg_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  z80_bus_t   bus,
	input  logic       dos,
	input  port_sel_t  sel,
	input  io_pulse_t  pulse,
	output paging_t    paging,
	output logic [7:0] peff7,
	output logic       shadow,
	output logic       p7ffd_wr,
	output logic       p7ffd_1m_on,
	output logic       p7ffd_ram0_0,
	output logic       set_nmi,
	output logic       clr_nmi
);

	logic [7:0] p7ffd;
	logic [7:0] peff7_int;
	logic       shadow_en;   // bf bit 0
	logic       block1m;

	assign shadow = dos | shadow_en;

	// a15 low only, bit 5 locks the port until reset
	assign p7ffd_wr = sel.fd & pulse.port_wr & ~bus.addr[15] & ~p7ffd[5];

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= 8'h00;
			peff7_int <= 8'h00;
			shadow_en <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else
		begin
			if (p7ffd_wr)
				p7ffd <= bus.din;
			if (sel.f7 & pulse.port_wr & ~bus.addr[12] & ~shadow)   // eff7 ignored in shadow
				peff7_int <= bus.din;
			if (sel.bf & pulse.port_wr)
			begin
				shadow_en <= bus.din[0];
				set_nmi   <= bus.din[3];
			end
		end
	end

	assign clr_nmi = sel.be & pulse.port_wr;   // nmi handler exit

	////////////////////
	assign block1m      = peff7_int[2];
	assign peff7        = block1m ? (peff7_int & 8'b1011_0001) : peff7_int;
	assign p7ffd_1m_on  = ~peff7_int[2];
	assign p7ffd_ram0_0 = peff7_int[3];

	assign paging.p7ffd     = p7ffd;
	assign paging.peff7_raw = peff7_int;

endmodule

// File: read_mux.sv
////////////////////
// z80 read data multiplexer
////////////////////
`timescale 1ns/1ps
`include "zports_macros.svh"

module read_mux
	import z80bus_pkg::*;
	import portcfg_pkg::*;
(
	input  z80_bus_t    bus,
	input  port_sel_t   sel,
	input  logic [31:0] xt_page,
	input  logic        shadow,
	input  logic        set_nmi,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic        dma_act,
	output logic [7:0]  dout
);

	logic [7:0] hoa;
	logic [7:0] xt_dout;

	assign hoa = bus.addr[15:8];

	// only status and the upper two pages read back on #nnAF
	always_comb
	begin
		case (hoa)
			`XT_STAT:               xt_dout = {dma_act, 7'b000_0000};
			`XT_RAMPAGE + 8'd2:     xt_dout = xt_page[23:16];
			`XT_RAMPAGE + 8'd3:     xt_dout = xt_page[31:24];
			default:                xt_dout = 8'hFF;
		endcase
	end

	always_comb
	begin
		if (sel.fe | sel.f6)
			dout = {1'b1, tape_read, 1'b0, keys_in};   // keyboard and tape in
		else if (sel.xt)
			dout = xt_dout;
		else if (sel.kjoy)
			dout = {3'b000, kj_in};
		else if (sel.kmouse)
			dout = mus_in;
		else if (sel.bf)
			dout = {4'b0000, set_nmi, 2'b00, shadow};
		else
			dout = 8'hFF;   // floating bus
	end

endmodule

// File: zports.sv
////////////////////
// z80 i/o port block, top level
////////////////////
`timescale 1ns/1ps

module zports
	import z80bus_pkg::*;
	import portcfg_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  z80_bus_t    bus,
	input  logic [4:0]  keys_in,    // port fe
	input  logic        tape_read,
	input  logic [4:0]  kj_in,      // kempston joystick
	input  logic [7:0]  mus_in,     // mouse
	input  logic        dos,
	input  logic        dma_act,
	output logic [7:0]  dout,
	output logic        porthit,
	output logic        dataout,
	output xt_cfg_t     cfg,
	output logic [31:0] xt_page,
	output vid_wr_t     vid_wr,
	output logic [8:0]  dmaport_wr,
	output logic        p7ffd_rom,
	output logic        romrw_en,
	output paging_t     paging,
	output logic [7:0]  peff7,
	output logic        shadow,
	output logic        p7ffd_1m_on,
	output logic        p7ffd_ram0_0,
	output logic        set_nmi,
	output logic        clr_nmi
);

	io_pulse_t pulse;
	port_sel_t sel;
	logic      p7ffd_wr;

	io_strobe u_strobe (.zclk(zclk), .rst_n(rst_n), .bus(bus), .pulse(pulse));

	port_decode u_decode
	(
		.bus(bus), .shadow(shadow), .sel(sel),
		.porthit(porthit), .dataout(dataout)
	);

	paging_regs u_paging
	(
		.zclk(zclk), .rst_n(rst_n), .bus(bus), .dos(dos), .sel(sel), .pulse(pulse),
		.paging(paging), .peff7(peff7), .shadow(shadow), .p7ffd_wr(p7ffd_wr),
		.p7ffd_1m_on(p7ffd_1m_on), .p7ffd_ram0_0(p7ffd_ram0_0),
		.set_nmi(set_nmi), .clr_nmi(clr_nmi)
	);

	xt_regs u_xt
	(
		.zclk(zclk), .rst_n(rst_n), .bus(bus), .sel_xt(sel.xt), .pulse(pulse),
		.p7ffd_wr(p7ffd_wr), .cfg(cfg), .xt_page(xt_page), .vid_wr(vid_wr),
		.sel_fe(sel.fe), .dmaport_wr(dmaport_wr),
		.p7ffd_rom(p7ffd_rom), .romrw_en(romrw_en)
	);

	read_mux u_rdmux
	(
		.bus(bus), .sel(sel), .xt_page(xt_page), .shadow(shadow), .set_nmi(set_nmi),
		.keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
		.dma_act(dma_act), .dout(dout)
	);

endmodule

// File: tb_zports_vectors.svh
////////////////////
// stimulus and expected-value table
// columns are op, port address or probe/input id, data and expected value
////////////////////

	task automatic load_table();
		// state after reset
		add_row(OP_CHK,        PR_XT_PAGE, 8'h00, 32'h0002_0500);
		add_row(OP_RD,         16'h12AF,   8'h00, 32'h02);
		add_row(OP_RD,         16'h13AF,   8'h00, 32'h00);
		add_row(OP_RD,         16'h00AF,   8'h00, 32'h00);
		add_row(OP_SET,        IN_DMA,     8'h01, 32'h0);
		add_row(OP_RD,         16'h00AF,   8'h00, 32'h80);   // dma busy bit
		add_row(OP_SET,        IN_DMA,     8'h00, 32'h0);

		// extension registers and strobes
		add_row(OP_WR,         16'h11AF,   8'h3C, 32'h0);
		add_row(OP_CHK,        PR_XT_PAGE, 8'h00, 32'h0002_3C00);
		add_row(OP_CHK,        PR_OVERR,   8'h00, 32'h2);
		add_row(OP_WR,         16'h20AF,   8'h5A, 32'h0);
		add_row(OP_CHK,        PR_SYSCONF, 8'h00, 32'h5A);
		add_row(OP_WR,         16'h25AF,   8'h7E, 32'h0);
		add_row(OP_CHK,        PR_IM2VECT, 8'h00, 32'h7E);
		add_row(OP_CNT_VCONF,  16'h00AF,   8'h11, 32'd1);
		add_row(OP_CNT_BORDER, 16'h0FAF,   8'h07, 32'd1);
		add_row(OP_CNT_DMA0,   16'h1AAF,   8'h34, 32'd1);

		////////////////////
		// 7ffd paging, lock128, lock bit
		add_row(OP_WR,         16'h7FFD,   8'h13, 32'h0);
		add_row(OP_CHK,        PR_XT_PAGE, 8'h00, 32'h0302_3C00);
		add_row(OP_CHK,        PR_ROM,     8'h00, 32'h1);
		add_row(OP_WR,         16'h7FFD,   8'hC2, 32'h0);
		add_row(OP_RD,         16'h13AF,   8'h00, 32'h1A);
		add_row(OP_CHK,        PR_ROM,     8'h00, 32'h0);
		add_row(OP_WR,         16'h21AF,   8'h02, 32'h0);   // rom write enable
		add_row(OP_CHK,        PR_ROMRW,   8'h00, 32'h1);
		add_row(OP_WR,         16'h21AF,   8'h40, 32'h0);   // lock128
		add_row(OP_CHK,        PR_ROMRW,   8'h00, 32'h0);
		add_row(OP_WR,         16'h7FFD,   8'hC2, 32'h0);
		add_row(OP_RD,         16'h13AF,   8'h00, 32'h02);
		add_row(OP_WR,         16'h7FFD,   8'h25, 32'h0);   // bit 5 locks
		add_row(OP_WR,         16'h7FFD,   8'h17, 32'h0);
		add_row(OP_RD,         16'h13AF,   8'h00, 32'h05);
		add_row(OP_CHK,        PR_ROM,     8'h00, 32'h0);
		add_row(OP_CHK,        PR_P7FFD,   8'h00, 32'h25);

		// eff7 and the block1m mask
		add_row(OP_WR,         16'hEFF7,   8'h0F, 32'h0);
		add_row(OP_CHK,        PR_PEFF7,   8'h00, 32'h01);
		add_row(OP_CHK,        PR_1M_ON,   8'h00, 32'h0);
		add_row(OP_WR,         16'hEFF7,   8'h08, 32'h0);
		add_row(OP_CHK,        PR_PEFF7,   8'h00, 32'h08);
		add_row(OP_CHK,        PR_RAM0_0,  8'h00, 32'h1);
		add_row(OP_CHK,        PR_1M_ON,   8'h00, 32'h1);

		////////////////////
		// shadow mode gating
		add_row(OP_SET,        IN_KJ,      8'h15, 32'h0);
		add_row(OP_RD,         16'h001F,   8'h00, 32'h15);
		add_row(OP_WR,         16'h00BF,   8'h01, 32'h0);
		add_row(OP_CHK,        PR_SHADOW,  8'h00, 32'h1);
		add_row(OP_RD_OFF,     16'h001F,   8'h00, 32'hFF);
		add_row(OP_RD,         16'h00BF,   8'h00, 32'h01);
		add_row(OP_WR,         16'hEFF7,   8'h00, 32'h0);
		add_row(OP_WR,         16'hEEF7,   8'h00, 32'h0);   // a8 low path in shadow
		add_row(OP_CHK,        PR_PEFF7,   8'h00, 32'h08);
		add_row(OP_WR,         16'h00BF,   8'h00, 32'h0);
		add_row(OP_CHK,        PR_SHADOW,  8'h00, 32'h0);
		add_row(OP_RD,         16'h001F,   8'h00, 32'h15);

		// keyboard, tape and nmi
		add_row(OP_RD_KEYS,    16'h00FE,   8'h00, 32'h0);
		add_row(OP_RD_KEYS,    16'h7FFE,   8'h00, 32'h0);
		add_row(OP_RD_KEYS,    16'hBFFE,   8'h00, 32'h0);
		add_row(OP_RD_KEYS,    16'h00F6,   8'h00, 32'h0);
		add_row(OP_CNT_CLRNMI, 16'h00BE,   8'h00, 32'd1);
		add_row(OP_WR,         16'h00BF,   8'h08, 32'h0);
		add_row(OP_CHK,        PR_SET_NMI, 8'h00, 32'h1);
		add_row(OP_RD,         16'h00BF,   8'h00, 32'h08);
		add_row(OP_WR,         16'h00BF,   8'h00, 32'h0);
		add_row(OP_CHK,        PR_SET_NMI, 8'h00, 32'h0);
	endtask

// File: tb_zports.sv
////////////////////
// testbench for the z80 i/o port block
// bus-cycle tasks, table loop, closing report
////////////////////
`timescale 1ns/1ps

module tb_zports
	import z80bus_pkg::*;
	import portcfg_pkg::*;
();

	localparam int ACTIVE_CYC = 3;   // iorq with rd or wr held
	localparam int IDLE_CYC   = 2;

	// table operations
	localparam logic [3:0] OP_WR         = 4'd0;
	localparam logic [3:0] OP_RD         = 4'd1;   // internal port with dataout high
	localparam logic [3:0] OP_RD_OFF     = 4'd2;   // no port hit
	localparam logic [3:0] OP_RD_KEYS    = 4'd3;
	localparam logic [3:0] OP_SET        = 4'd4;
	localparam logic [3:0] OP_CHK        = 4'd5;
	localparam logic [3:0] OP_CNT_VCONF  = 4'd6;
	localparam logic [3:0] OP_CNT_BORDER = 4'd7;
	localparam logic [3:0] OP_CNT_DMA0   = 4'd8;
	localparam logic [3:0] OP_CNT_CLRNMI = 4'd9;

	// probe ids for OP_CHK rows
	localparam logic [15:0] PR_XT_PAGE = 16'd0;
	localparam logic [15:0] PR_OVERR   = 16'd1;
	localparam logic [15:0] PR_SYSCONF = 16'd2;
	localparam logic [15:0] PR_IM2VECT = 16'd3;
	localparam logic [15:0] PR_ROM     = 16'd4;
	localparam logic [15:0] PR_P7FFD   = 16'd5;
	localparam logic [15:0] PR_PEFF7   = 16'd6;
	localparam logic [15:0] PR_1M_ON   = 16'd7;
	localparam logic [15:0] PR_RAM0_0  = 16'd8;
	localparam logic [15:0] PR_SET_NMI = 16'd9;
	localparam logic [15:0] PR_SHADOW  = 16'd10;
	localparam logic [15:0] PR_ROMRW   = 16'd11;

	// input ids for OP_SET rows
	localparam logic [15:0] IN_DMA = 16'd0;
	localparam logic [15:0] IN_KJ  = 16'd1;

	typedef struct packed
	{
		logic [3:0]  op;
		logic [15:0] addr;   // port address, probe or input id
		logic [7:0]  data;
		logic [31:0] exp;
	} row_t;

	logic        zclk;
	logic        rst_n;
	z80_bus_t    bus;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic        dos;
	logic        dma_act;
	logic [7:0]  dout;
	logic        porthit;
	logic        dataout;
	xt_cfg_t     cfg;
	logic [31:0] xt_page;
	vid_wr_t     vid_wr;
	logic [8:0]  dmaport_wr;
	logic        p7ffd_rom;
	logic        romrw_en;
	paging_t     paging;
	logic [7:0]  peff7;
	logic        shadow;
	logic        p7ffd_1m_on;
	logic        p7ffd_ram0_0;
	logic        set_nmi;
	logic        clr_nmi;

	row_t   rows[$];
	integer seed;
	int     val_errs;
	int     tmo_errs;

	zports dut0 (.*);

	initial
	begin
		zclk = 1'b0;
		forever #20 zclk = ~zclk;
	end

	function automatic void add_row(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [31:0] exp);
		rows.push_back(row_t'({op, addr, data, exp}));
	endfunction

	// level of the strobe a counting row watches
	function automatic logic strobe_level(input logic [3:0] op);
		case (op)
			OP_CNT_VCONF:  return vid_wr.vconf;
			OP_CNT_BORDER: return vid_wr.border;
			OP_CNT_DMA0:   return dmaport_wr[0];
			OP_CNT_CLRNMI: return clr_nmi;
			default:       return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] probe(input logic [15:0] id);
		case (id)
			PR_XT_PAGE: return xt_page;
			PR_OVERR:   return {28'h0, cfg.xt_override};
			PR_SYSCONF: return {24'h0, cfg.sysconf};
			PR_IM2VECT: return {24'h0, cfg.im2vect};
			PR_ROM:     return {31'h0, p7ffd_rom};
			PR_P7FFD:   return {24'h0, paging.p7ffd};
			PR_PEFF7:   return {24'h0, peff7};
			PR_1M_ON:   return {31'h0, p7ffd_1m_on};
			PR_RAM0_0:  return {31'h0, p7ffd_ram0_0};
			PR_SET_NMI: return {31'h0, set_nmi};
			PR_SHADOW:  return {31'h0, shadow};
			PR_ROMRW:   return {31'h0, romrw_en};
			default:    return 32'hFFFF_FFFF;
		endcase
	endfunction

`include "tb_zports_vectors.svh"

	////////////////////
	// one i/o cycle of active then idle phases
	task automatic bus_cycle(input logic is_wr, input logic [15:0] addr,
		input logic [7:0] data, input logic [3:0] op,
		output logic [7:0] rd_byte, output logic rd_hit, output logic rd_port,
		output int pulses);
		int   n;
		logic seen;
		pulses = 0;
		seen   = 1'b0;
		@(posedge zclk);
		bus.addr   <= addr;
		bus.din    <= data;
		bus.iorq_n <= 1'b0;
		bus.rd_n   <= is_wr;
		bus.wr_n   <= ~is_wr;
		// the io pulse must show within the cycle length
		for (n = 0; n < ACTIVE_CYC + IDLE_CYC; n++)
		begin
			if (n == ACTIVE_CYC)
			begin
				@(posedge zclk);
				bus.iorq_n <= 1'b1;
				bus.rd_n   <= 1'b1;
				bus.wr_n   <= 1'b1;
			end
			@(negedge zclk);
			if (n == 0)
			begin
				rd_byte = dout;   // combinational, same cycle
				rd_hit  = dataout;
				rd_port = porthit;
			end
			if (dut0.pulse.port_wr | dut0.pulse.port_rd)
				seen = 1'b1;
			pulses += strobe_level(op);
		end
		if (!seen)
		begin
			tmo_errs++;
			$display("timeout: no i/o pulse seen for the cycle on port %h", addr);
		end
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] got,
		input logic hit, input logic port, input logic [7:0] exp, input logic exp_hit);
		assert (got == exp)
		else
		begin
			val_errs++;
			$display("Fail %0t: read of port %h gave %h, expected %h", $time, addr, got, exp);
		end
		assert (hit == exp_hit)
		else
		begin
			val_errs++;
			$display("Fail %0t: dataout on port %h is %b, expected %b",
				$time, addr, hit, exp_hit);
		end
		assert (port == exp_hit)
		else
		begin
			val_errs++;
			$display("Fail %0t: porthit on port %h is %b, expected %b",
				$time, addr, port, exp_hit);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d wrong values, %0d timeouts", val_errs, tmo_errs);
		if (val_errs == 0 && tmo_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	////////////////////
	initial
	begin
		row_t        r;
		logic [7:0]  rd_byte;
		logic        rd_hit;
		logic        rd_port;
		int          pulses;
		logic [31:0] rnd;
		logic [31:0] got;
		seed       = 32'h7c40_742e;
		val_errs   = 0;
		tmo_errs   = 0;
		rst_n      <= 1'b0;
		bus.addr   <= 16'h0000;
		bus.din    <= 8'h00;
		bus.iorq_n <= 1'b1;
		bus.rd_n   <= 1'b1;
		bus.wr_n   <= 1'b1;
		keys_in    <= 5'h1F;
		tape_read  <= 1'b0;
		kj_in      <= 5'h00;
		mus_in     <= 8'hFF;
		dos        <= 1'b0;
		dma_act    <= 1'b0;
		load_table();
		repeat (2) @(posedge zclk);
		rst_n <= 1'b1;

		foreach (rows[i])
		begin
			r = rows[i];
			case (r.op)
				OP_SET:
				begin
					@(posedge zclk);
					if (r.addr == IN_DMA)
						dma_act <= r.data[0];
					else
						kj_in <= r.data[4:0];
				end
				OP_CHK:
				begin
					@(negedge zclk);
					got = probe(r.addr);
					assert (got == r.exp)
					else
					begin
						val_errs++;
						$display("Fail %0t: probe %0d is %h, expected %h",
							$time, r.addr, got, r.exp);
					end
				end
				OP_RD_KEYS:
				begin
					@(posedge zclk);
					rnd = $random(seed);
					keys_in   <= rnd[4:0];
					tape_read <= rnd[5];
					bus_cycle(1'b0, r.addr, 8'h00, r.op, rd_byte, rd_hit, rd_port, pulses);
					check_read(r.addr, rd_byte, rd_hit, rd_port,
						{1'b1, rnd[5], 1'b0, rnd[4:0]}, 1'b1);
				end
				OP_RD, OP_RD_OFF:
				begin
					bus_cycle(1'b0, r.addr, 8'h00, r.op, rd_byte, rd_hit, rd_port, pulses);
					check_read(r.addr, rd_byte, rd_hit, rd_port, r.exp[7:0], r.op == OP_RD);
				end
				default:   // plain writes and strobe counts
				begin
					bus_cycle(1'b1, r.addr, r.data, r.op, rd_byte, rd_hit, rd_port, pulses);
					if (r.op != OP_WR)
					begin
						assert (pulses == r.exp)
						else
						begin
							val_errs++;
							$display("Fail %0t: write to %h gave %0d strobe pulses, expected %0d",
								$time, r.addr, pulses, r.exp);
						end
					end
				end
			endcase
		end
		finish_run();
	end

endmodule

// File: filelist.f
+incdir+.
z80bus_pkg.sv
portcfg_pkg.sv
io_strobe.sv
port_decode.sv
xt_regs.sv
paging_regs.sv
read_mux.sv
zports.sv
tb_zports.sv
